// File: Bender.yml
package:
  name: spi_link

sources:
  # design, package first
  - files:
      - source/spi_link_pkg.sv
      - source/spi_iff.sv
      - source/spi_decoder.sv
      - source/spi_link_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - tb/spi_link_assert.sv
      - tb/spi_link_tb.sv

// File: project.f
source/spi_link_pkg.sv
source/spi_iff.sv
source/spi_decoder.sv
source/spi_link_top.sv
tb/spi_link_assert.sv
tb/spi_link_tb.sv

// File: source/spi_decoder.sv
// writes need the full length rule; unknown opcodes read as zero and change no register
module spi_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    // opcode of the running transaction
    input  spi_link_pkg::spi_byte_t      opcode,
    input  logic                         opcode_valid,
    // finished frame
    input  spi_link_pkg::cmd_frame_t     cmd_read,
    input  spi_link_pkg::byte_count_t    cmd_len_bytes,
    input  logic                         valid,
    // live rotor position
    input  spi_link_pkg::rotation_t      rotation_data,
    // reply bytes 1 to 6 for the interface block
    output spi_link_pkg::reply_t         reply,
    // driver state
    output spi_link_pkg::driver_config_t configuration,
    output logic                         new_config_available,
    output logic                         rgb_enable
);

    // opcode byte of the finished frame
    spi_link_pkg::spi_byte_t        frame_opcode;
    // bytes 1 to 6 of the finished frame
    spi_link_pkg::driver_config_t   frame_payload;
    // reply built from the current state
    spi_link_pkg::reply_t           reply_next;

    logic config_write;
    logic rgb_write;

    assign frame_opcode  = cmd_read[55:48];
    assign frame_payload = cmd_read[47:0];

    // reply selection
    always_comb begin
        reply_next = '0;
        case (opcode)
            spi_link_pkg::op_read_rotation: begin
                // rotation word goes out on bytes 1 and 2
                reply_next[47:32] = rotation_data;
            end
            spi_link_pkg::op_read_config: begin
                reply_next = configuration;
            end
            spi_link_pkg::op_read_status: begin
                // bit 0 of byte 1
                reply_next[40] = rgb_enable;
            end
            default: begin
                // write opcodes and unknown ones read back zeros
                reply_next = '0;
            end
        endcase
    end

    // reply is stable from the cycle after opcode_valid until the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reply <= '0;
        end else if (opcode_valid) begin
            reply <= reply_next;
        end
    end

    // config write needs the opcode plus exactly six payload bytes
    assign config_write = valid &&
                          (frame_opcode == spi_link_pkg::op_write_config) &&
                          (cmd_len_bytes == spi_link_pkg::config_len_bytes);

    // rgb write needs at least the flag byte
    assign rgb_write = valid &&
                       (frame_opcode == spi_link_pkg::op_write_rgb) &&
                       (cmd_len_bytes >= spi_link_pkg::rgb_min_bytes);

    // configuration and its strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            configuration        <= '0;
            new_config_available <= 1'b0;
        end else begin
            new_config_available <= 1'b0;
            if (config_write) begin
                configuration        <= frame_payload;
                new_config_available <= 1'b1;
            end
        end
    end

    // rgb enable flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb_enable <= 1'b0;
        end else if (rgb_write) begin
            // bit 0 of byte 1 only, the rest of the byte is ignored
            rgb_enable <= frame_payload[40];
        end
    end

endmodule

// File: source/spi_iff.sv
// SPI mode 0 slave only; sclk high and low phases need at least 4 clk cycles, sync_stages 2 or 3
module spi_iff #(
    parameter int sync_stages = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // SPI pins, asynchronous to clk
    input  logic                      spi_sclk,
    input  logic                      spi_cs_n,
    input  logic                      spi_mosi,
    output logic                      spi_miso,
    // reply bytes 1 to 6 from the decoder
    input  spi_link_pkg::reply_t      reply,
    // first byte of the transaction
    output spi_link_pkg::spi_byte_t   opcode,
    output logic                      opcode_valid,
    // whole frame after chip select rises
    output spi_link_pkg::cmd_frame_t  cmd_read,
    output spi_link_pkg::byte_count_t cmd_len_bytes,
    output logic                      valid
);

    // synchronizer chains, newest sample in bit 0
    logic [sync_stages-1:0] sclk_sync;
    logic [sync_stages-1:0] cs_sync;
    logic [sync_stages-1:0] mosi_sync;

    // previous synchronized levels for edge detection
    logic sclk_prev;
    logic cs_prev;

    logic sclk_q;
    logic cs_q;
    logic mosi_q;
    logic sclk_rise;
    logic sclk_fall;
    logic cs_rise;
    logic cs_fall;

    spi_link_pkg::iff_state_t  state;
    logic [2:0]                bit_cnt;
    spi_link_pkg::byte_count_t byte_cnt;
    // reply must be loaded at the next falling sclk edge
    logic                      reply_pend;

    // datapath
    spi_link_pkg::spi_byte_t   shift_in;
    spi_link_pkg::spi_byte_t   rx_byte;
    spi_link_pkg::cmd_frame_t  frame;
    spi_link_pkg::reply_t      tx_shift;
    logic                      byte_done;

    // all three pins go through the same depth so mosi stays aligned to sclk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
            cs_prev   <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[sync_stages-2:0], spi_sclk};
            cs_sync   <= {cs_sync[sync_stages-2:0], spi_cs_n};
            mosi_sync <= {mosi_sync[sync_stages-2:0], spi_mosi};
            sclk_prev <= sclk_q;
            cs_prev   <= cs_q;
        end
    end

    assign sclk_q = sclk_sync[sync_stages-1];
    assign cs_q   = cs_sync[sync_stages-1];
    assign mosi_q = mosi_sync[sync_stages-1];

    assign sclk_rise = sclk_q & ~sclk_prev;
    assign sclk_fall = ~sclk_q & sclk_prev;
    assign cs_rise   = cs_q & ~cs_prev;
    assign cs_fall   = ~cs_q & cs_prev;

    // byte as it stands after the current mosi bit, msb first
    assign rx_byte   = {shift_in[6:0], mosi_q};
    // eighth rising edge of a byte
    assign byte_done = (state == spi_link_pkg::st_shift) && sclk_rise && (bit_cnt == 3'd7);

    // control FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= spi_link_pkg::st_idle;
            bit_cnt       <= '0;
            byte_cnt      <= '0;
            reply_pend    <= 1'b0;
            opcode_valid  <= 1'b0;
            valid         <= 1'b0;
            cmd_len_bytes <= '0;
            spi_miso      <= 1'b0;
        end else begin
            // pulses last one cycle
            opcode_valid <= 1'b0;
            valid        <= 1'b0;
            case (state)
                spi_link_pkg::st_idle: begin
                    if (cs_fall) begin
                        state      <= spi_link_pkg::st_shift;
                        bit_cnt    <= '0;
                        byte_cnt   <= '0;
                        reply_pend <= 1'b0;
                        // byte 0 on miso is all zeros
                        spi_miso   <= 1'b0;
                    end
                end
                spi_link_pkg::st_shift: begin
                    if (cs_rise) begin
                        state <= spi_link_pkg::st_finish;
                        // nothing to report without a complete byte
                        if (byte_cnt != '0) begin
                            valid         <= 1'b1;
                            cmd_len_bytes <= byte_cnt;
                        end
                    end else begin
                        if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                        if (byte_done) begin
                            if (byte_cnt == '0) begin
                                opcode_valid <= 1'b1;
                                reply_pend   <= 1'b1;
                            end
                            // extra bytes are shifted but the count saturates
                            if (byte_cnt != spi_link_pkg::max_len_bytes) begin
                                byte_cnt <= byte_cnt + 3'd1;
                            end
                        end
                        if (sclk_fall) begin
                            if (reply_pend) begin
                                reply_pend <= 1'b0;
                                spi_miso   <= reply[47];
                            end else begin
                                spi_miso <= tx_shift[47];
                            end
                        end
                    end
                end
                spi_link_pkg::st_finish: begin
                    state      <= spi_link_pkg::st_idle;
                    bit_cnt    <= '0;
                    byte_cnt   <= '0;
                    reply_pend <= 1'b0;
                    spi_miso   <= 1'b0;
                end
                default: begin
                    state <= spi_link_pkg::st_idle;
                end
            endcase
        end
    end

    // datapath registers follow the FSM events
    always_ff @(posedge clk) begin
        if ((state == spi_link_pkg::st_idle) && cs_fall) begin
            frame    <= '0;
            tx_shift <= '0;
        end else if (state == spi_link_pkg::st_shift) begin
            if (cs_rise) begin
                // frame is held until the next valid
                if (byte_cnt != '0) begin
                    cmd_read <= frame;
                end
            end else begin
                if (sclk_rise) begin
                    shift_in <= rx_byte;
                end
                if (byte_done && (byte_cnt != spi_link_pkg::max_len_bytes)) begin
                    // left aligned, byte 0 lands in the top eight bits
                    frame[8 * (6 - int'(byte_cnt)) +: 8] <= rx_byte;
                end
                if (byte_done && (byte_cnt == '0)) begin
                    opcode <= rx_byte;
                end
                if (sclk_fall) begin
                    // bit 47 goes straight to miso on the load edge
                    if (reply_pend) begin
                        tx_shift <= {reply[46:0], 1'b0};
                    end else begin
                        tx_shift <= {tx_shift[46:0], 1'b0};
                    end
                end
            end
        end
    end

endmodule

// File: source/spi_link_pkg.sv
// shared widths, opcodes and the interface FSM states; frames are fixed at seven bytes maximum
package spi_link_pkg;

    // one byte as it travels on mosi or miso
    typedef logic [7:0] spi_byte_t;

    // received command, opcode in the top byte, unreceived bytes read as zero
    typedef logic [55:0] cmd_frame_t;

    // number of complete bytes in a frame, 1 to 7
    typedef logic [2:0] byte_count_t;

    // six reply bytes that follow the opcode byte on miso
    typedef logic [47:0] reply_t;

    // rotor position word from the encoder logic
    typedef logic [15:0] rotation_t;

    // driver configuration, bytes 1 to 6 of a config write
    typedef logic [47:0] driver_config_t;

    // opcodes, byte 0 of every transaction
    localparam spi_byte_t op_read_rotation = 8'h01;
    localparam spi_byte_t op_write_config  = 8'h02;
    localparam spi_byte_t op_read_config   = 8'h03;
    localparam spi_byte_t op_write_rgb     = 8'h04;
    localparam spi_byte_t op_read_status   = 8'h05;

    // byte counts that the write rules compare against
    localparam byte_count_t config_len_bytes = 3'd7;
    localparam byte_count_t rgb_min_bytes    = 3'd2;
    localparam byte_count_t max_len_bytes    = 3'd7;

    // interface FSM
    // st_idle   waits for chip select to fall
    // st_shift  shifts bits while chip select is low
    // st_finish one cycle after chip select rises, valid is high here
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_shift  = 2'd1,
        st_finish = 2'd2
    } iff_state_t;

endpackage

// File: source/spi_link_top.sv
// clk and rst_n come from outside; end-of-transaction latency depends on sync_stages
module spi_link_top #(
    parameter int sync_stages = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    // SPI slave pins
    input  logic                         spi_sclk,
    input  logic                         spi_cs_n,
    input  logic                         spi_mosi,
    output logic                         spi_miso,
    // rotor position, sampled when a read opcode arrives
    input  spi_link_pkg::rotation_t      rotation_data,
    // driver state
    output spi_link_pkg::driver_config_t configuration,
    output logic                         new_config_available,
    output logic                         rgb_enable
);

    // opcode path, used for the reply
    spi_link_pkg::spi_byte_t   opcode;
    logic                      opcode_valid;
    spi_link_pkg::reply_t      reply;

    // finished frame path, used for writes
    spi_link_pkg::cmd_frame_t  cmd_read;
    spi_link_pkg::byte_count_t cmd_len_bytes;
    logic                      cmd_valid;

    spi_iff #(
        .sync_stages(sync_stages)
    ) spi_iff_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .spi_sclk     (spi_sclk),
        .spi_cs_n     (spi_cs_n),
        .spi_mosi     (spi_mosi),
        .spi_miso     (spi_miso),
        .reply        (reply),
        .opcode       (opcode),
        .opcode_valid (opcode_valid),
        .cmd_read     (cmd_read),
        .cmd_len_bytes(cmd_len_bytes),
        .valid        (cmd_valid)
    );

    spi_decoder spi_decoder_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .opcode              (opcode),
        .opcode_valid        (opcode_valid),
        .cmd_read            (cmd_read),
        .cmd_len_bytes       (cmd_len_bytes),
        .valid               (cmd_valid),
        .rotation_data       (rotation_data),
        .reply               (reply),
        .configuration       (configuration),
        .new_config_available(new_config_available),
        .rgb_enable          (rgb_enable)
    );

endmodule

// File: tb/spi_link_assert.sv
// bound into spi_link_top; assumes the frame valid is the cmd_valid net of the top level
module spi_link_assert (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      valid,
    input spi_link_pkg::byte_count_t cmd_len_bytes,
    input logic                      new_config_available
);
    timeunit 1ns;
    timeprecision 1ps;

    // frame valid is a one-cycle pulse per transaction
    valid_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        valid |=> !valid)
        else $error("frame valid stayed high for more than one cycle");

    // a published frame always holds at least the opcode byte
    valid_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> (cmd_len_bytes != '0))
        else $error("frame valid with a zero byte count");

    // config strobe follows the frame valid by exactly one cycle
    config_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
        new_config_available |-> $past(valid))
        else $error("new_config_available without a frame valid one cycle before");

endmodule

bind spi_link_top spi_link_assert spi_link_assert_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .valid               (cmd_valid),
    .cmd_len_bytes       (cmd_len_bytes),
    .new_config_available(new_config_available)
);

// File: tb/spi_link_tb.sv
// runs spi_link_top at sync_stages 2 with 6-cycle sclk phases; transfers of at most 9 bytes
module spi_link_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // timing in clk cycles, except the half period in ns
    localparam int half_period   = 20;
    localparam int sclk_phase    = 6;
    localparam int settle_cycles = 16;
    localparam int drain_timeout = 1000;

    logic                         clk;
    logic                         rst_n;
    logic                         spi_sclk;
    logic                         spi_cs_n;
    logic                         spi_mosi;
    logic                         spi_miso;
    spi_link_pkg::rotation_t      rotation_data;
    spi_link_pkg::driver_config_t configuration;
    logic                         new_config_available;
    logic                         rgb_enable;

    // reference model state
    logic [47:0] model_config;
    logic        model_rgb;
    int          model_pulses;

    // checks waiting for the compare process
    string       chk_name_q[$];
    logic [71:0] chk_exp_q[$];
    logic [71:0] chk_got_q[$];

    int check_count;
    int error_count;
    int test_count;
    int test_checks;
    int test_errors;

    spi_link_top #(
        .sync_stages(2)
    ) dut_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .spi_sclk            (spi_sclk),
        .spi_cs_n            (spi_cs_n),
        .spi_mosi            (spi_mosi),
        .spi_miso            (spi_miso),
        .rotation_data       (rotation_data),
        .configuration       (configuration),
        .new_config_available(new_config_available),
        .rgb_enable          (rgb_enable)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // expected miso bytes of one transfer, left aligned; also applies the write effects
    function automatic logic [71:0] expected_reply(input logic [71:0] tx, input int n_bits,
                                                   input logic [15:0] rot);
        int          n_bytes;
        logic [7:0]  op;
        logic [47:0] rep;
        n_bytes      = n_bits / 8;
        op           = tx[71:64];
        rep          = '0;
        model_pulses = 0;
        // count saturates at seven bytes
        if (n_bytes > 7) begin
            n_bytes = 7;
        end
        if (n_bytes == 0) begin
            return '0;
        end
        case (op)
            spi_link_pkg::op_read_rotation: rep[47:32] = rot;
            spi_link_pkg::op_read_config:   rep = model_config;
            spi_link_pkg::op_read_status:   rep[40] = model_rgb;
            default:                        rep = '0;
        endcase
        // writes land after chip select rises, so the reply above sees the old state
        if ((op == spi_link_pkg::op_write_config) && (n_bytes == 7)) begin
            model_config = tx[63:16];
            model_pulses = 1;
        end
        if ((op == spi_link_pkg::op_write_rgb) && (n_bytes >= 2)) begin
            model_rgb = tx[56];
        end
        // byte 0 is zeros, bytes past the seventh shift out zeros
        return {8'h00, rep, 16'h0000};
    endfunction

    task automatic push_check(input string name, input logic [71:0] exp_val,
                              input logic [71:0] got_val);
        chk_name_q.push_back(name);
        chk_exp_q.push_back(exp_val);
        chk_got_q.push_back(got_val);
    endtask

    // compares queued results one per falling clk edge
    always @(negedge clk) begin : compare_results
        string       name;
        logic [71:0] exp_val;
        logic [71:0] got_val;
        if (chk_name_q.size() > 0) begin
            name    = chk_name_q.pop_front();
            exp_val = chk_exp_q.pop_front();
            got_val = chk_got_q.pop_front();
            check_count++;
            if (got_val !== exp_val) begin
                $display("Error at %0t ns: %s expected %h got %h", $time, name, exp_val,
                         got_val);
                error_count++;
            end
        end
    end

    // mode 0 master, msb first; miso is sampled just before each rising sclk
    task automatic spi_transfer(input logic [71:0] tx, input int n_bits,
                                output logic [71:0] rx);
        int i;
        rx = '0;
        @(posedge clk);
        #2;
        spi_cs_n = 1'b0;
        spi_mosi = tx[71];
        for (i = 0; i < n_bits; i++) begin
            repeat (sclk_phase) @(posedge clk);
            #2;
            rx[71 - i] = spi_miso;
            spi_sclk   = 1'b1;
            repeat (sclk_phase) @(posedge clk);
            #2;
            spi_sclk = 1'b0;
            // next bit goes out with the falling sclk
            spi_mosi = (i + 1 < n_bits) ? tx[70 - i] : 1'b0;
        end
        repeat (sclk_phase) @(posedge clk);
        #2;
        spi_cs_n = 1'b1;
    endtask

    task automatic run_transaction(input string name, input logic [71:0] tx, input int n_bits);
        logic [71:0] exp_miso;
        logic [71:0] got_miso;
        logic [71:0] mask;
        int          pulses;
        exp_miso = expected_reply(tx, n_bits, rotation_data);
        // only the clocked bits are compared
        mask     = ~({72{1'b1}} >> n_bits);
        spi_transfer(tx, n_bits, got_miso);
        pulses = 0;
        // window is well past the cs-to-output latency
        repeat (settle_cycles) begin
            @(negedge clk);
            if (new_config_available) begin
                pulses++;
            end
        end
        push_check({name, " spi_miso"}, exp_miso & mask, got_miso & mask);
        push_check({name, " new_config_available pulses"}, 72'(model_pulses), 72'(pulses));
        push_check({name, " configuration"}, 72'(model_config), 72'(configuration));
        push_check({name, " rgb_enable"}, 72'(model_rgb), 72'(rgb_enable));
    endtask

    // waits for the compare process, then reports the test
    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while ((chk_name_q.size() > 0) && (waited < drain_timeout)) begin
            @(negedge clk);
            waited++;
        end
        if (chk_name_q.size() > 0) begin
            $display("compare process did not finish within %0d cycles", drain_timeout);
            error_count++;
        end
        test_count++;
        $display("test %0d %s: %0d checks, %0d errors", test_count, name,
                 check_count - test_checks, error_count - test_errors);
        test_checks = check_count;
        test_errors = error_count;
    endtask

    initial begin : main_seq
        logic [63:0] rnd;
        void'($urandom(32'haf62_a686));
        rst_n         = 1'b0;
        spi_sclk      = 1'b0;
        spi_cs_n      = 1'b1;
        spi_mosi      = 1'b0;
        rotation_data = '0;
        model_config  = '0;
        model_rgb     = 1'b0;
        model_pulses  = 0;
        check_count   = 0;
        error_count   = 0;
        test_count    = 0;
        test_checks   = 0;
        test_errors   = 0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // reset values, then a read of the cleared configuration
        @(negedge clk);
        push_check("configuration after reset", '0, 72'(configuration));
        push_check("rgb_enable after reset", '0, 72'(rgb_enable));
        push_check("new_config_available after reset", '0, 72'(new_config_available));
        run_transaction("read config", {spi_link_pkg::op_read_config, 64'h0}, 56);
        finish_test("reset state");

        // rotation word held steady over each transfer
        repeat (10) begin
            @(posedge clk);
            #2;
            rotation_data = spi_link_pkg::rotation_t'($urandom);
            run_transaction("read rotation", {spi_link_pkg::op_read_rotation, 64'h0}, 56);
        end
        finish_test("read rotation");

        rnd = {$urandom, $urandom};
        run_transaction("write config", {spi_link_pkg::op_write_config, rnd[47:0], 16'h0}, 56);
        run_transaction("read config", {spi_link_pkg::op_read_config, 64'h0}, 56);
        finish_test("config write and read back");

        // short write and unknown opcode must leave the config alone
        rnd = {$urandom, $urandom};
        run_transaction("short config write", {spi_link_pkg::op_write_config, rnd}, 40);
        run_transaction("unknown opcode", {8'h7e, rnd}, 56);
        run_transaction("read config", {spi_link_pkg::op_read_config, 64'h0}, 56);
        finish_test("ignored writes");

        run_transaction("rgb on", {spi_link_pkg::op_write_rgb, 8'h01, 56'h0}, 16);
        run_transaction("read status", {spi_link_pkg::op_read_status, 64'h0}, 56);
        run_transaction("rgb off", {spi_link_pkg::op_write_rgb, 8'h00, 56'h0}, 16);
        run_transaction("read status", {spi_link_pkg::op_read_status, 64'h0}, 56);
        finish_test("rgb enable");

        // extra bytes are dropped, a partial last byte kills the write
        rnd = {$urandom, $urandom};
        run_transaction("long config write", {spi_link_pkg::op_write_config, rnd}, 72);
        run_transaction("read config", {spi_link_pkg::op_read_config, 64'h0}, 56);
        rnd = {$urandom, $urandom};
        run_transaction("cut config write", {spi_link_pkg::op_write_config, rnd}, 52);
        run_transaction("read config", {spi_link_pkg::op_read_config, 64'h0}, 56);
        finish_test("long and cut transfers");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
